// ==== logic/tpu_pkg.sv ====
`default_nettype none

package tpu_pkg;

    // Activations and weights are both signed and share one width.
    localparam int DATA_W = 8;

    // Accumulator entries are signed and wide enough for many summed products.
    localparam int ACC_W = 24;

    // Selects how a masked write treats the entry already in the bank.
    typedef enum logic {
        OP_OVERWRITE  = 1'b0,
        OP_ACCUMULATE = 1'b1
    } accum_op_e;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        FILL  = 3'd1,
        FULL  = 3'd2,
        DRAIN = 3'd3,
        DONE  = 3'd4
    } accum_state_e;

endpackage

`default_nettype wire

// ==== logic/act_credit_buffer.sv ====
`default_nettype none

module act_credit_buffer #(
    parameter int CREDITS = 4
) (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        push_i,
    input  wire  [tpu_pkg::DATA_W-1:0] push_data_i,
    input  wire                        pop_i,
    output logic                       buf_valid_o,
    output logic [tpu_pkg::DATA_W-1:0] buf_data_o,
    output logic                       credit_o
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [tpu_pkg::DATA_W-1:0] mem [CREDITS];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           count_q;
    logic                       do_pop;

    // Pointers wrap at the buffer depth, which need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign buf_valid_o = (count_q != '0);
    assign buf_data_o  = mem[rd_ptr_q];
    assign do_pop      = pop_i && buf_valid_o;

    // The host only pushes while holding a credit, so a push never finds the buffer full.
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Every freed slot goes back to the host as one credit.
            credit_o <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mac_lane_chain.sv ====
`default_nettype none

module mac_lane_chain #(
    parameter  int MUL_SIZE = 4,
    localparam int LANE_W   = (MUL_SIZE > 1) ? $clog2(MUL_SIZE) : 1
) (
    input  wire                                          clk_i,
    input  wire                                          rst_n_i,
    input  wire                                          wt_load_i,
    input  wire  [LANE_W-1:0]                            wt_lane_i,
    input  wire  [tpu_pkg::DATA_W-1:0]                   wt_data_i,
    input  wire                                          step_i,
    input  wire  [tpu_pkg::DATA_W-1:0]                   step_data_i,
    output logic [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]      prod_o
);

    localparam int MUL_W = 2 * tpu_pkg::DATA_W;

    logic signed [tpu_pkg::DATA_W-1:0] wt_q  [MUL_SIZE];
    logic signed [tpu_pkg::DATA_W-1:0] act_q [MUL_SIZE];
    logic signed [tpu_pkg::DATA_W-1:0] act_d [MUL_SIZE];
    logic signed [MUL_W-1:0]           mul   [MUL_SIZE];

    // Lane 0 takes the incoming value and every other lane takes its left neighbour.
    always_comb begin
        act_d[0] = step_data_i;
        for (int k = 1; k < MUL_SIZE; k++) begin
            act_d[k] = act_q[k-1];
        end
    end

    // The product is formed from the value the lane is about to hold,
    // so it is registered in the same edge as the shift.
    always_comb begin
        for (int k = 0; k < MUL_SIZE; k++) begin
            mul[k] = act_d[k] * wt_q[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (wt_load_i) begin
            wt_q[wt_lane_i] <= wt_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < MUL_SIZE; k++) begin
                act_q[k] <= '0;
            end
            prod_o <= '0;
        end else if (step_i) begin
            for (int k = 0; k < MUL_SIZE; k++) begin
                act_q[k]  <= act_d[k];
                prod_o[k] <= tpu_pkg::ACC_W'(mul[k]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/accum_step_counter.sv ====
`default_nettype none

module accum_step_counter #(
    parameter  int MUL_SIZE  = 4,
    parameter  int ACC_DEPTH = 16,
    localparam int ROWS_W    = $clog2(ACC_DEPTH + 1),
    localparam int STEP_W    = $clog2(ACC_DEPTH + MUL_SIZE)
) (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 clear_i,
    input  wire                 step_i,
    input  wire  [ROWS_W-1:0]   rows_i,
    output logic [STEP_W-1:0]   step_idx_o,
    output logic                last_pop_o,
    output logic                last_step_o,
    output logic                wr_en_o,
    output logic [STEP_W-1:0]   wr_row_o,
    output logic [MUL_SIZE-1:0] lane_mask_o
);

    logic [ROWS_W-1:0]   rows_q;
    logic [MUL_SIZE-1:0] lane_en;

    // The last activation enters at step rows-1 and the last lane finishes
    // MUL_SIZE-1 steps later.
    assign last_pop_o  = (step_idx_o == STEP_W'(rows_q) - 1'b1);
    assign last_step_o = (step_idx_o == STEP_W'(rows_q) + STEP_W'(MUL_SIZE - 2));

    // Lane k sees activation step_idx-k, which is real only inside 0..rows-1.
    always_comb begin
        for (int k = 0; k < MUL_SIZE; k++) begin
            lane_en[k] = (step_idx_o >= STEP_W'(k)) &&
                         (step_idx_o < STEP_W'(k) + STEP_W'(rows_q));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_idx_o  <= '0;
            rows_q      <= '0;
            wr_en_o     <= 1'b0;
            lane_mask_o <= '0;
        end else begin
            if (clear_i) begin
                step_idx_o <= '0;
                rows_q     <= rows_i;
            end else if (step_i) begin
                step_idx_o <= step_idx_o + 1'b1;
            end
            wr_en_o     <= step_i;
            lane_mask_o <= step_i ? lane_en : '0;
        end
    end

    // The row follows the step by one cycle to line up with the registered products.
    always_ff @(posedge clk_i) begin
        if (step_i) begin
            wr_row_o <= step_idx_o;
        end
    end

endmodule

`default_nettype wire

// ==== logic/accum_ctrl_fsm.sv ====
`default_nettype none

module accum_ctrl_fsm #(
    parameter int MUL_SIZE = 4
) (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 start_i,
    input  wire                 op_i,
    input  wire                 buf_valid_i,
    input  wire                 last_pop_i,
    input  wire                 last_step_i,
    input  wire                 wr_en_i,
    output logic                pop_o,
    output logic                step_o,
    output logic                bubble_o,
    output logic                clear_o,
    output tpu_pkg::accum_op_e  op_o,
    output logic                busy_o,
    output logic                done_o
);

    localparam int FILL_W = $clog2(MUL_SIZE + 1);

    tpu_pkg::accum_state_e state_q;
    tpu_pkg::accum_state_e state_d;
    logic [FILL_W-1:0]     fill_cnt_q;
    logic                  fill_last;

    // The chain is full once MUL_SIZE activations have been shifted in.
    assign fill_last = (fill_cnt_q == FILL_W'(MUL_SIZE - 1));

    always_comb begin
        state_d  = state_q;
        pop_o    = 1'b0;
        bubble_o = 1'b0;
        clear_o  = 1'b0;
        done_o   = 1'b0;
        case (state_q)
            tpu_pkg::IDLE: begin
                if (start_i) begin
                    clear_o = 1'b1;
                    state_d = tpu_pkg::FILL;
                end
            end
            tpu_pkg::FILL: begin
                pop_o = buf_valid_i;
                if (pop_o) begin
                    // A short pass skips the full phase altogether.
                    if (last_pop_i) begin
                        state_d = last_step_i ? tpu_pkg::DONE : tpu_pkg::DRAIN;
                    end else if (fill_last) begin
                        state_d = tpu_pkg::FULL;
                    end
                end
            end
            tpu_pkg::FULL: begin
                pop_o = buf_valid_i;
                if (pop_o && last_pop_i) begin
                    state_d = last_step_i ? tpu_pkg::DONE : tpu_pkg::DRAIN;
                end
            end
            tpu_pkg::DRAIN: begin
                bubble_o = 1'b1;
                if (last_step_i) begin
                    state_d = tpu_pkg::DONE;
                end
            end
            tpu_pkg::DONE: begin
                // The final write is still in flight while wr_en_i is high.
                if (!wr_en_i) begin
                    done_o  = 1'b1;
                    state_d = tpu_pkg::IDLE;
                end
            end
            default: begin
                state_d = tpu_pkg::IDLE;
            end
        endcase
    end

    assign step_o = pop_o || bubble_o;
    assign busy_o = (state_q != tpu_pkg::IDLE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= tpu_pkg::IDLE;
            fill_cnt_q <= '0;
            op_o       <= tpu_pkg::OP_OVERWRITE;
        end else begin
            state_q <= state_d;
            if (clear_o) begin
                fill_cnt_q <= '0;
                op_o       <= tpu_pkg::accum_op_e'(op_i);
            end else if (state_q == tpu_pkg::FILL && step_o) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/accum_bank.sv ====
`default_nettype none

module accum_bank #(
    parameter  int MUL_SIZE  = 4,
    parameter  int ACC_DEPTH = 16,
    localparam int STEP_W    = $clog2(ACC_DEPTH + MUL_SIZE),
    localparam int ADDR_W    = $clog2(ACC_DEPTH)
) (
    input  wire                                      clk_i,
    input  wire                                      rst_n_i,
    input  wire                                      wr_en_i,
    input  wire  [STEP_W-1:0]                        wr_row_i,
    input  wire  [MUL_SIZE-1:0]                      lane_mask_i,
    input  wire  [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  prod_i,
    input  tpu_pkg::accum_op_e                       op_i,
    input  wire                                      rd_en_i,
    input  wire  [ADDR_W-1:0]                        rd_addr_i,
    output logic [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  rd_row_o
);

    for (genvar k = 0; k < MUL_SIZE; k++) begin : g_col
        logic [tpu_pkg::ACC_W-1:0] mem [ACC_DEPTH];
        logic [STEP_W-1:0]         row;
        logic [tpu_pkg::ACC_W-1:0] wr_data;
        logic [tpu_pkg::ACC_W-1:0] rd_q;

        // Lane k lags lane 0 by k steps, so its row is shifted back by k.
        assign row = wr_row_i - STEP_W'(k);

        assign wr_data = (op_i == tpu_pkg::OP_ACCUMULATE) ?
                         mem[row[ADDR_W-1:0]] + prod_i[k] : prod_i[k];

        always_ff @(posedge clk_i) begin
            if (wr_en_i && lane_mask_i[k]) begin
                mem[row[ADDR_W-1:0]] <= wr_data;
            end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_q <= '0;
            end else if (rd_en_i) begin
                rd_q <= mem[rd_addr_i];
            end
        end

        assign rd_row_o[k] = rd_q;
    end

endmodule

`default_nettype wire

// ==== logic/tpu_accum_top.sv ====
`default_nettype none

module tpu_accum_top #(
    parameter  int MUL_SIZE  = 4,
    parameter  int ACC_DEPTH = 16,
    parameter  int CREDITS   = 4,
    localparam int LANE_W    = (MUL_SIZE > 1) ? $clog2(MUL_SIZE) : 1,
    localparam int ROWS_W    = $clog2(ACC_DEPTH + 1),
    localparam int ADDR_W    = $clog2(ACC_DEPTH),
    localparam int STEP_W    = $clog2(ACC_DEPTH + MUL_SIZE)
) (
    input  wire                                      clk_i,
    input  wire                                      rst_n_i,
    input  wire                                      act_valid_i,
    input  wire  [tpu_pkg::DATA_W-1:0]               act_data_i,
    output logic                                     credit_o,
    input  wire                                      wt_load_i,
    input  wire  [LANE_W-1:0]                        wt_lane_i,
    input  wire  [tpu_pkg::DATA_W-1:0]               wt_data_i,
    input  wire                                      start_i,
    input  wire                                      op_i,
    input  wire  [ROWS_W-1:0]                        rows_i,
    input  wire                                      rd_en_i,
    input  wire  [ADDR_W-1:0]                        rd_addr_i,
    output logic [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  rd_row_o,
    output logic                                     busy_o,
    output logic                                     done_o
);

    logic                                     buf_valid;
    logic [tpu_pkg::DATA_W-1:0]               buf_data;
    logic                                     pop;
    logic                                     step;
    logic                                     bubble;
    logic                                     clear;
    tpu_pkg::accum_op_e                       op;
    logic [tpu_pkg::DATA_W-1:0]               step_data;
    logic                                     wt_load;
    logic                                     last_pop;
    logic                                     last_step;
    logic                                     wr_en;
    logic [STEP_W-1:0]                        wr_row;
    logic [MUL_SIZE-1:0]                      lane_mask;
    logic [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  prod;

    // Drain steps push zero bubbles, and weights stay fixed during a pass.
    assign step_data = bubble ? '0 : buf_data;
    assign wt_load   = wt_load_i && !busy_o;

    act_credit_buffer #(
        .CREDITS (CREDITS)
    ) act_credit_buffer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (act_valid_i),
        .push_data_i (act_data_i),
        .pop_i       (pop),
        .buf_valid_o (buf_valid),
        .buf_data_o  (buf_data),
        .credit_o    (credit_o)
    );

    accum_ctrl_fsm #(
        .MUL_SIZE (MUL_SIZE)
    ) accum_ctrl_fsm_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .op_i        (op_i),
        .buf_valid_i (buf_valid),
        .last_pop_i  (last_pop),
        .last_step_i (last_step),
        .wr_en_i     (wr_en),
        .pop_o       (pop),
        .step_o      (step),
        .bubble_o    (bubble),
        .clear_o     (clear),
        .op_o        (op),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    mac_lane_chain #(
        .MUL_SIZE (MUL_SIZE)
    ) mac_lane_chain_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wt_load_i   (wt_load),
        .wt_lane_i   (wt_lane_i),
        .wt_data_i   (wt_data_i),
        .step_i      (step),
        .step_data_i (step_data),
        .prod_o      (prod)
    );

    accum_step_counter #(
        .MUL_SIZE  (MUL_SIZE),
        .ACC_DEPTH (ACC_DEPTH)
    ) accum_step_counter_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear),
        .step_i      (step),
        .rows_i      (rows_i),
        .step_idx_o  (),
        .last_pop_o  (last_pop),
        .last_step_o (last_step),
        .wr_en_o     (wr_en),
        .wr_row_o    (wr_row),
        .lane_mask_o (lane_mask)
    );

    accum_bank #(
        .MUL_SIZE  (MUL_SIZE),
        .ACC_DEPTH (ACC_DEPTH)
    ) accum_bank_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_en_i     (wr_en),
        .wr_row_i    (wr_row),
        .lane_mask_i (lane_mask),
        .prod_i      (prod),
        .op_i        (op),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_row_o    (rd_row_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== tb/tpu_accum_chk.sv ====
`default_nettype none

module tpu_accum_chk #(
    parameter int MUL_SIZE = 4,
    parameter int CREDITS  = 4
) (
    input wire                                     clk_i,
    input wire                                     rst_n_i,
    input wire                                     start_i,
    input wire                                     act_valid_i,
    input wire                                     credit_i,
    input wire                                     busy_i,
    input wire                                     done_i,
    input wire                                     pop_i,
    input wire                                     step_i,
    input wire                                     wr_en_i,
    input wire                                     rd_en_i,
    input wire [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  rd_row_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int outstanding_q;
    int fail_cnt = 0;

    // Activations taken by the buffer minus the credits already handed back.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q + int'(act_valid_i) - int'(credit_i);
        end
    end

    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        outstanding_q <= CREDITS)
        else begin
            $error("more activations outstanding than credits");
            fail_cnt++;
        end

    a_push_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        act_valid_i |-> outstanding_q < CREDITS)
        else begin
            $error("activation pushed without a credit");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !busy_i && !done_i && !credit_i && !pop_i && !wr_en_i)
        else begin
            $error("control outputs active during reset");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> busy_i ##1 (!done_i && !busy_i))
        else begin
            $error("done is not a single pulse that ends busy");
            fail_cnt++;
        end

    a_busy_after_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i && !busy_i |=> busy_i)
        else begin
            $error("busy did not rise after start");
            fail_cnt++;
        end

    // Done comes two cycles after the final step.
    a_done_after_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> !$past(step_i) && $past(step_i, 2))
        else begin
            $error("done not two cycles after the final step");
            fail_cnt++;
        end

    a_read_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd_row_i != $past(rd_row_i)) |-> $past(rd_en_i))
        else begin
            $error("read row changed without a read one cycle earlier");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== tb/tpu_accum_tb.sv ====
`default_nettype none

module tpu_accum_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MUL_SIZE   = 4;
    localparam int ACC_DEPTH  = 16;
    localparam int CREDITS    = 4;
    localparam int SHORT_ROWS = 3;
    localparam int CLK_PERIOD = 100;
    localparam int LANE_W     = 2;
    localparam int ROWS_W     = 5;
    localparam int ADDR_W     = 4;
    // Four full passes, the short pass and the pass of exactly MUL_SIZE rows.
    localparam int TOTAL_STEPS = 4 * (ACC_DEPTH + MUL_SIZE - 1)
                                 + (SHORT_ROWS + MUL_SIZE - 1) + (2 * MUL_SIZE - 1);

    logic                                     clk;
    logic                                     rst_n;
    logic                                     act_valid;
    logic [tpu_pkg::DATA_W-1:0]               act_data;
    logic                                     credit;
    logic                                     wt_load;
    logic [LANE_W-1:0]                        wt_lane;
    logic [tpu_pkg::DATA_W-1:0]               wt_data;
    logic                                     start;
    logic                                     op;
    logic [ROWS_W-1:0]                        rows;
    logic                                     rd_en;
    logic [ADDR_W-1:0]                        rd_addr;
    logic [MUL_SIZE-1:0][tpu_pkg::ACC_W-1:0]  rd_row;
    logic                                     busy;
    logic                                     done;

    int                         weight [MUL_SIZE];
    int                         expect_mem [ACC_DEPTH][MUL_SIZE];
    logic [tpu_pkg::DATA_W-1:0] act_queue [$];
    int                         credits;
    bit                         starve;
    int                         errors;
    int                         tests_run;
    int                         tests_failed;
    int                         chk_fails;

    tb_clock_gen #(
        .PERIOD (CLK_PERIOD)
    ) tb_clock_gen_i (
        .clk_o (clk)
    );

    tpu_accum_top #(
        .MUL_SIZE  (MUL_SIZE),
        .ACC_DEPTH (ACC_DEPTH),
        .CREDITS   (CREDITS)
    ) tpu_accum_top_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .act_valid_i (act_valid),
        .act_data_i  (act_data),
        .credit_o    (credit),
        .wt_load_i   (wt_load),
        .wt_lane_i   (wt_lane),
        .wt_data_i   (wt_data),
        .start_i     (start),
        .op_i        (op),
        .rows_i      (rows),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_row_o    (rd_row),
        .busy_o      (busy),
        .done_o      (done)
    );

    bind tpu_accum_top tpu_accum_chk #(
        .MUL_SIZE (MUL_SIZE),
        .CREDITS  (CREDITS)
    ) tpu_accum_chk_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .act_valid_i (act_valid_i),
        .credit_i    (credit_o),
        .busy_i      (busy_o),
        .done_i      (done_o),
        .pop_i       (pop),
        .step_i      (step),
        .wr_en_i     (wr_en),
        .rd_en_i     (rd_en_i),
        .rd_row_i    (rd_row_o)
    );

    // Host side of the credit loop. A starved host skips most cycles at random.
    always @(posedge clk) begin
        if (credit) begin
            credits = credits + 1;
        end
        if (rst_n && credits > 0 && act_queue.size() > 0 &&
            !(starve && $urandom_range(0, 2) != 0)) begin
            act_valid <= 1'b1;
            act_data  <= act_queue.pop_front();
            credits = credits - 1;
        end else begin
            act_valid <= 1'b0;
        end
    end

    task automatic load_weights();
        for (int k = 0; k < MUL_SIZE; k++) begin
            @(posedge clk);
            wt_load <= 1'b1;
            wt_lane <= LANE_W'(k);
            wt_data <= tpu_pkg::DATA_W'(weight[k]);
        end
        @(posedge clk);
        wt_load <= 1'b0;
    endtask

    // Queues the activations, updates the model, then runs one pass to done.
    task automatic run_pass(input tpu_pkg::accum_op_e pass_op, input int n_rows,
                            input bit interfere);
        int a;
        for (int t = 0; t < n_rows; t++) begin
            a = $signed(tpu_pkg::DATA_W'($urandom));
            act_queue.push_back(tpu_pkg::DATA_W'(a));
            for (int k = 0; k < MUL_SIZE; k++) begin
                if (pass_op == tpu_pkg::OP_ACCUMULATE) begin
                    expect_mem[t][k] += a * weight[k];
                end else begin
                    expect_mem[t][k] = a * weight[k];
                end
            end
        end
        @(posedge clk);
        start <= 1'b1;
        op    <= pass_op;
        rows  <= ROWS_W'(n_rows);
        @(posedge clk);
        start <= 1'b0;
        if (interfere) begin
            repeat (3) @(posedge clk);
            start   <= 1'b1;
            rows    <= ROWS_W'(1);
            wt_load <= 1'b1;
            wt_lane <= '0;
            wt_data <= tpu_pkg::DATA_W'(weight[0] + 1);
            @(posedge clk);
            start   <= 1'b0;
            wt_load <= 1'b0;
        end
        while (!done) begin
            @(posedge clk);
        end
    endtask

    task automatic check_rows(input string name);
        int got;
        int mismatches;
        mismatches = 0;
        for (int r = 0; r < ACC_DEPTH; r++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= ADDR_W'(r);
            @(posedge clk);
            rd_en <= 1'b0;
            @(posedge clk);
            for (int k = 0; k < MUL_SIZE; k++) begin
                got = $signed(rd_row[k]);
                assert (got == expect_mem[r][k]) else begin
                    $display("FAILED %s row %0d lane %0d expected %0d actual %0d",
                             name, r, k, expect_mem[r][k], got);
                    mismatches++;
                end
            end
        end
        tests_run++;
        if (mismatches == 0) begin
            $display("test %s finished, all rows match", name);
        end else begin
            $display("test %s finished with %0d mismatches", name, mismatches);
            tests_failed++;
            errors += mismatches;
        end
    endtask

    initial begin
        #(CLK_PERIOD * (20 * TOTAL_STEPS + 1000));
        $display("watchdog expired before all tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(48595));
        rst_n        = 1'b0;
        act_valid    = 1'b0;
        act_data     = '0;
        wt_load      = 1'b0;
        wt_lane      = '0;
        wt_data      = '0;
        start        = 1'b0;
        op           = 1'b0;
        rows         = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        credits      = CREDITS;
        starve       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int k = 0; k < MUL_SIZE; k++) begin
            weight[k] = $signed(tpu_pkg::DATA_W'($urandom));
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        load_weights();

        run_pass(tpu_pkg::OP_OVERWRITE, ACC_DEPTH, 1'b0);
        check_rows("overwrite_full");
        run_pass(tpu_pkg::OP_ACCUMULATE, ACC_DEPTH, 1'b0);
        check_rows("accumulate_full");
        run_pass(tpu_pkg::OP_OVERWRITE, SHORT_ROWS, 1'b0);
        check_rows("short_pass");
        starve = 1'b1;
        run_pass(tpu_pkg::OP_OVERWRITE, ACC_DEPTH, 1'b0);
        check_rows("starved_supply");
        starve = 1'b0;
        run_pass(tpu_pkg::OP_OVERWRITE, MUL_SIZE, 1'b0);
        check_rows("control_timing");
        starve = 1'b1;
        run_pass(tpu_pkg::OP_ACCUMULATE, ACC_DEPTH, 1'b1);
        check_rows("busy_interference");

        chk_fails = tpu_accum_top_i.tpu_accum_chk_i.fail_cnt;
        $display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, chk_fails);
        if (errors == 0 && tests_failed == 0 && chk_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/tpu_pkg.sv
logic/act_credit_buffer.sv
logic/mac_lane_chain.sv
logic/accum_step_counter.sv
logic/accum_ctrl_fsm.sv
logic/accum_bank.sv
logic/tpu_accum_top.sv
tb/tb_clock_gen.sv
tb/tpu_accum_chk.sv
tb/tpu_accum_tb.sv

// ==== Makefile ====
TOP = tpu_accum_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^Regression passed$$"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
